/* conv_ctrl_pkg.sv */
package conv_ctrl_pkg;

        // Geometry of one frame
        localparam int num_channels = 3;
        localparam int num_lanes = 8;
        localparam int num_taps = 25;   // A 5x5 kernel flattened to one sequence

        typedef logic [1:0] channel_t;

        typedef logic [4:0] tap_t;

        typedef logic [2:0] lane_t;

        // The output drain is the only FSM in the layer
        typedef enum logic {
                drain_idle,
                drain_busy
        } drain_state_t;

endpackage

/* conv_types_pkg.sv */
package conv_types_pkg;

        // Widths of the number formats along the datapath
        localparam int sample_w = 12;
        localparam int weight_w = 8;
        localparam int acc_w = 25;     // 25 products of 20 bits need 5 guard bits
        localparam int chsum_w = 27;   // Room for the sum of three lane totals
        localparam int result_w = 12;

        // Output scaling is a divide by 256 followed by clipping
        localparam int scale_shift = 8;
        localparam int result_max = 2047;
        localparam int result_min = -2048;

        typedef logic signed [sample_w-1:0] sample_t;

        typedef logic signed [weight_w-1:0] weight_t;

        typedef logic signed [acc_w-1:0] acc_t;

        typedef logic signed [chsum_w-1:0] chsum_t;

        typedef logic signed [result_w-1:0] result_t;

        // One sample per lane of every channel, channel is the outer index
        typedef sample_t [conv_ctrl_pkg::num_channels-1:0][conv_ctrl_pkg::num_lanes-1:0]
                samples_t;

endpackage

/* mac_bus_if.sv */
`timescale 1ns/1ps

interface mac_bus_if;

        import conv_types_pkg::*;
        import conv_ctrl_pkg::*;

        logic en;       // One registered beat for the lanes
        logic first;    // Beat holds tap 0, lanes restart their sums
        logic last;     // Beat holds the final tap of the frame
        samples_t samples;
        weight_t [num_channels-1:0] weights;

        modport feeder (
                output en,
                output first,
                output last,
                output samples,
                output weights
        );

        modport array (
                input en,
                input first,
                input last,
                input samples,
                input weights
        );

endinterface

/* weight_bank.sv */
`timescale 1ns/1ps

module weight_bank (
        input  logic clk,
        input  logic rst,
        input  logic weight_we,
        input  conv_ctrl_pkg::channel_t weight_channel,
        input  conv_ctrl_pkg::tap_t weight_tap,
        input  conv_types_pkg::weight_t weight_data,
        input  conv_ctrl_pkg::tap_t tap,
        output conv_types_pkg::weight_t [conv_ctrl_pkg::num_channels-1:0] weights
);

        import conv_types_pkg::*;
        import conv_ctrl_pkg::*;

        weight_t [num_channels-1:0][num_taps-1:0] weight_regs;

        // Writes that fall outside the kernel are dropped
        always_ff @(posedge clk) begin
                if (rst) begin
                        weight_regs <= '0;
                end else if (weight_we && weight_channel < num_channels &&
                             weight_tap < num_taps) begin
                        weight_regs[weight_channel][weight_tap] <= weight_data;
                end
        end

        // Every channel reads the same tap in the same cycle
        always_comb begin
                for (int c = 0; c < num_channels; c++) begin
                        weights[c] = weight_regs[c][tap];
                end
        end

endmodule

/* tap_sequencer.sv */
`timescale 1ns/1ps

module tap_sequencer (
        input  logic clk,
        input  logic rst,
        input  logic valid_in,
        input  conv_types_pkg::samples_t in_samples,
        output conv_ctrl_pkg::tap_t tap,
        input  conv_types_pkg::weight_t [conv_ctrl_pkg::num_channels-1:0] weights,
        mac_bus_if.feeder bus
);

        import conv_ctrl_pkg::*;

        logic tap_is_last;

        assign tap_is_last = (tap == tap_t'(num_taps - 1));

        // Tap counter moves on beats only, so idle gaps inside a frame are harmless
        always_ff @(posedge clk) begin
                if (rst) begin
                        tap <= '0;
                        bus.en <= 1'b0;
                        bus.first <= 1'b0;
                        bus.last <= 1'b0;
                end else begin
                        bus.en <= valid_in;
                        if (valid_in) begin
                                bus.first <= (tap == '0);
                                bus.last <= tap_is_last;
                                if (tap_is_last)
                                        tap <= '0;
                                else
                                        tap <= tap + tap_t'(1);
                        end
                end
        end

        // Samples and the weights of the current tap travel together
        always_ff @(posedge clk) begin
                if (valid_in) begin
                        bus.samples <= in_samples;
                        bus.weights <= weights;
                end
        end

endmodule

/* mac_array.sv */
`timescale 1ns/1ps

module mac_array (
        input  logic clk,
        input  logic rst,
        mac_bus_if.array bus,
        output conv_types_pkg::acc_t
                [conv_ctrl_pkg::num_channels-1:0][conv_ctrl_pkg::num_lanes-1:0] totals,
        output logic totals_valid
);

        import conv_types_pkg::*;
        import conv_ctrl_pkg::*;

        logic frame_done;       // Accumulators hold a completed frame

        always_ff @(posedge clk) begin
                if (rst) begin
                        frame_done <= 1'b0;
                        totals_valid <= 1'b0;
                end else begin
                        frame_done <= bus.en & bus.last;
                        totals_valid <= frame_done;
                end
        end

        for (genvar c = 0; c < num_channels; c++) begin : g_channel
                for (genvar l = 0; l < num_lanes; l++) begin : g_lane
                        acc_t prod;
                        acc_t acc;
                        acc_t total;

                        // Both factors are sign extended to the accumulator width
                        assign prod = $signed(bus.samples[c][l]) * $signed(bus.weights[c]);

                        // Copying to total frees acc for the next frame right away
                        always_ff @(posedge clk) begin
                                if (bus.en) begin
                                        if (bus.first)
                                                acc <= prod;
                                        else
                                                acc <= acc + prod;
                                end
                                if (frame_done)
                                        total <= acc;
                        end

                        assign totals[c][l] = total;
                end
        end

endmodule

/* result_drain.sv */
`timescale 1ns/1ps

module result_drain (
        input  logic clk,
        input  logic rst,
        input  conv_types_pkg::acc_t
                [conv_ctrl_pkg::num_channels-1:0][conv_ctrl_pkg::num_lanes-1:0] totals,
        input  logic totals_valid,
        output logic valid_out,
        output conv_types_pkg::result_t conv_out
);

        import conv_types_pkg::*;
        import conv_ctrl_pkg::*;

        drain_state_t state;
        lane_t lane_cnt;                // Lane currently on conv_out
        result_t [num_lanes-1:0] lane_results;
        result_t [num_lanes-1:0] out_buf;

        // Channel sum, divide by 256, then clip to the output range
        always_comb begin
                chsum_t lane_sum;
                chsum_t scaled;
                for (int l = 0; l < num_lanes; l++) begin
                        lane_sum = '0;
                        for (int c = 0; c < num_channels; c++) begin
                                lane_sum = lane_sum + $signed(totals[c][l]);
                        end
                        scaled = lane_sum >>> scale_shift;
                        if (scaled > result_max)
                                lane_results[l] = result_t'(result_max);
                        else if (scaled < result_min)
                                lane_results[l] = result_t'(result_min);
                        else
                                lane_results[l] = result_t'(scaled);
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        state <= drain_idle;
                        lane_cnt <= '0;
                end else begin
                        case (state)
                                drain_idle: begin
                                        if (totals_valid) begin
                                                state <= drain_busy;
                                                lane_cnt <= '0;
                                        end
                                end
                                drain_busy: begin
                                        if (lane_cnt == lane_t'(num_lanes - 1))
                                                state <= drain_idle;
                                        lane_cnt <= lane_cnt + lane_t'(1);
                                end
                                default: state <= drain_idle;
                        endcase
                end
        end

        // Lane 0 leaves first, the rest move down one place per cycle
        always_ff @(posedge clk) begin
                if (totals_valid)
                        out_buf <= lane_results;
                else if (state == drain_busy)
                        out_buf <= {result_t'(0), out_buf[num_lanes-1:1]};
        end

        assign conv_out = out_buf[0];
        assign valid_out = (state == drain_busy);

endmodule

/* conv_layer_top.sv */
`timescale 1ns/1ps

module conv_layer_top (
        input  logic clk,
        input  logic rst,
        input  logic weight_we,
        input  conv_ctrl_pkg::channel_t weight_channel,
        input  conv_ctrl_pkg::tap_t weight_tap,
        input  conv_types_pkg::weight_t weight_data,
        input  logic valid_in,
        input  conv_types_pkg::samples_t in_samples,
        output logic valid_out,
        output conv_types_pkg::result_t conv_out
);

        import conv_types_pkg::*;
        import conv_ctrl_pkg::*;

        tap_t tap;
        weight_t [num_channels-1:0] weights;
        acc_t [num_channels-1:0][num_lanes-1:0] totals;
        logic totals_valid;

        mac_bus_if bus0 ();

        weight_bank weight_bank0 (
                .clk            (clk),
                .rst            (rst),
                .weight_we      (weight_we),
                .weight_channel (weight_channel),
                .weight_tap     (weight_tap),
                .weight_data    (weight_data),
                .tap            (tap),
                .weights        (weights)
        );

        tap_sequencer tap_sequencer0 (
                .clk        (clk),
                .rst        (rst),
                .valid_in   (valid_in),
                .in_samples (in_samples),
                .tap        (tap),
                .weights    (weights),
                .bus        (bus0.feeder)
        );

        mac_array mac_array0 (
                .clk          (clk),
                .rst          (rst),
                .bus          (bus0.array),
                .totals       (totals),
                .totals_valid (totals_valid)
        );

        result_drain result_drain0 (
                .clk          (clk),
                .rst          (rst),
                .totals       (totals),
                .totals_valid (totals_valid),
                .valid_out    (valid_out),
                .conv_out     (conv_out)
        );

endmodule

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
        output logic clk
);

        localparam int half_period = 4;        // 8 ns clock period

        initial begin
                clk = 1'b0;
        end

        always #half_period clk = ~clk;

endmodule

/* conv_layer_tb.sv */
`timescale 1ns/1ps

module conv_layer_tb;

        import conv_types_pkg::*;
        import conv_ctrl_pkg::*;

        localparam int max_cycles = 4000;

        logic clk;
        logic rst;
        logic weight_we;
        channel_t weight_channel;
        tap_t weight_tap;
        weight_t weight_data;
        logic valid_in;
        samples_t in_samples;
        logic valid_out;
        result_t conv_out;

        integer seed = 5;
        int cycle_cnt = 0;
        int errors = 0;
        int checks = 0;
        int out_idx = 0;                // Lane expected next on conv_out
        int exp_val;
        int weight_copy [num_channels][num_taps];
        int frame_samples [num_taps][num_channels][num_lanes];
        int exp_q [$];                  // Expected results in output order
        int beat_q [$];                 // Edge that sampled the last beat of each frame

        tb_clock clk_gen0 (.clk(clk));

        conv_layer_top dut0 (
                .clk            (clk),
                .rst            (rst),
                .weight_we      (weight_we),
                .weight_channel (weight_channel),
                .weight_tap     (weight_tap),
                .weight_data    (weight_data),
                .valid_in       (valid_in),
                .in_samples     (in_samples),
                .valid_out      (valid_out),
                .conv_out       (conv_out)
        );

        task automatic idle_cycles(input int n);
                for (int i = 0; i < n; i++) begin
                        @(posedge clk);
                        #1;
                        valid_in = 1'b0;
                end
        endtask

        // Mode 0 loads random weights, mode 1 the most negative, mode 2 the most positive
        task automatic load_weights(input int mode);
                int w;
                for (int c = 0; c < num_channels; c++) begin
                        for (int t = 0; t < num_taps; t++) begin
                                case (mode)
                                        1: w = -128;
                                        2: w = 127;
                                        default: w = $random(seed) % 128;
                                endcase
                                weight_copy[c][t] = w;
                                @(posedge clk);
                                #1;
                                valid_in = 1'b0;
                                weight_we = 1'b1;
                                weight_channel = channel_t'(c);
                                weight_tap = tap_t'(t);
                                weight_data = weight_t'(w);
                        end
                end
                @(posedge clk);
                #1;
                weight_we = 1'b0;
        endtask

        // Dot product per lane over all taps and channels, then divide by 256 and clip
        task automatic queue_expected();
                int sum;
                int scaled;
                for (int l = 0; l < num_lanes; l++) begin
                        sum = 0;
                        for (int c = 0; c < num_channels; c++) begin
                                for (int t = 0; t < num_taps; t++) begin
                                        sum = sum + frame_samples[t][c][l] * weight_copy[c][t];
                                end
                        end
                        scaled = sum >>> 8;
                        if (scaled > 2047)
                                scaled = 2047;
                        else if (scaled < -2048)
                                scaled = -2048;
                        exp_q.push_back(scaled);
                end
        endtask

        task automatic send_frame(input bit with_gaps, input bit extreme);
                int val;
                for (int t = 0; t < num_taps; t++) begin
                        if (with_gaps) begin
                                while ({$random(seed)} % 100 >= 70) begin
                                        @(posedge clk);
                                        #1;
                                        valid_in = 1'b0;
                                end
                        end
                        for (int c = 0; c < num_channels; c++) begin
                                for (int l = 0; l < num_lanes; l++) begin
                                        if (extreme)
                                                val = (l % 2 == 0) ? -2048 : 2047;
                                        else
                                                val = $random(seed) % 2048;
                                        frame_samples[t][c][l] = val;
                                end
                        end
                        @(posedge clk);
                        #1;
                        valid_in = 1'b1;
                        for (int c = 0; c < num_channels; c++) begin
                                for (int l = 0; l < num_lanes; l++) begin
                                        in_samples[c][l] = sample_t'(frame_samples[t][c][l]);
                                end
                        end
                end
                queue_expected();
                beat_q.push_back(cycle_cnt + 1);        // The next edge samples tap 24
        endtask

        task automatic wait_drained();
                while (exp_q.size() != 0) begin
                        @(posedge clk);
                end
                idle_cycles(2);
        endtask

        always @(posedge clk) begin
                cycle_cnt = cycle_cnt + 1;
                if (cycle_cnt >= max_cycles) begin
                        $display("ERROR: run stopped after %0d cycles", cycle_cnt);
                        $display("Checks: %0d, errors: %0d", checks, errors + 1);
                        $display("tests failed");
                        $finish;
                end
        end

        // Outputs are sampled on the falling edge, where they are stable
        always @(negedge clk) begin
                if (!rst) begin
                        if (valid_out) begin
                                if (exp_q.size() == 0 || beat_q.size() == 0) begin
                                        $display("ERROR at %0t: valid_out high with no result due",
                                                 $time);
                                        errors++;
                                end else begin
                                        exp_val = exp_q.pop_front();
                                        checks++;
                                        if (conv_out !== result_t'(exp_val)) begin
                                                $display("FAIL at %0t: conv_out expected %0d actual %0d",
                                                         $time, result_t'(exp_val), conv_out);
                                                errors++;
                                        end
                                        checks++;
                                        if (cycle_cnt != beat_q[0] + 3 + out_idx) begin
                                                $display("FAIL at %0t: valid_out cycle expected %0d actual %0d",
                                                         $time, beat_q[0] + 3 + out_idx, cycle_cnt);
                                                errors++;
                                        end
                                        if (out_idx == num_lanes - 1) begin
                                                out_idx = 0;
                                                beat_q.delete(0);
                                        end else begin
                                                out_idx++;
                                        end
                                end
                        end else if (out_idx != 0) begin
                                $display("ERROR at %0t: valid_out fell after %0d results",
                                         $time, out_idx);
                                errors++;
                                out_idx = 0;
                                beat_q.delete(0);
                        end else if (beat_q.size() != 0 && cycle_cnt > beat_q[0] + 3) begin
                                $display("ERROR at %0t: no results 3 cycles after the last beat",
                                         $time);
                                errors++;
                                beat_q.delete(0);
                                for (int k = 0; k < num_lanes; k++) begin
                                        if (exp_q.size() != 0)
                                                exp_q.delete(0);
                                end
                        end
                end
        end

        initial begin
                rst = 1'b1;
                weight_we = 1'b0;
                weight_channel = '0;
                weight_tap = '0;
                weight_data = '0;
                valid_in = 1'b0;
                in_samples = '0;
                repeat (10) @(posedge clk);
                #1;
                rst = 1'b0;

                idle_cycles(20);                // Nothing may come out before a frame

                load_weights(0);
                send_frame(1'b0, 1'b0);
                idle_cycles(1);
                wait_drained();

                load_weights(0);
                repeat (3) send_frame(1'b1, 1'b0);
                idle_cycles(1);
                wait_drained();

                load_weights(0);
                repeat (4) send_frame(1'b0, 1'b0);      // Drain overlaps the next frame
                idle_cycles(1);
                wait_drained();

                load_weights(1);
                send_frame(1'b0, 1'b1);
                idle_cycles(1);
                wait_drained();
                load_weights(2);
                send_frame(1'b0, 1'b1);
                idle_cycles(1);
                wait_drained();

                load_weights(0);
                repeat (2) send_frame(1'b1, 1'b0);
                idle_cycles(12);
                wait_drained();

                if (exp_q.size() != 0 || beat_q.size() != 0) begin
                        $display("ERROR: %0d expected results never appeared", exp_q.size());
                        errors++;
                end
                $display("Checks: %0d, errors: %0d", checks, errors);
                if (errors == 0)
                        $display("all tests passed");
                else
                        $display("tests failed");
                $finish;
        end

endmodule

/* verilog.f */
conv_ctrl_pkg.sv
conv_types_pkg.sv
mac_bus_if.sv
weight_bank.sv
tap_sequencer.sv
mac_array.sv
result_drain.sv
conv_layer_top.sv
tb_clock.sv
conv_layer_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line

verilator --binary --timing -j 0 -f verilog.f --top-module conv_layer_tb \
        -o conv_layer_sim &&
        ./obj_dir/conv_layer_sim | tee /dev/stderr | grep -q "^all tests passed$" &&
        echo "Simulation passed" ||
        { echo "Simulation failed"; exit 1; }
